// ==== common/div_msg_pkg.sv ====
// message level types of the iterative divider
// request and response formats, decode to execute bundle, sign flags
`default_nettype none

package div_msg_pkg;

  // operand width, fixed by the message format
  localparam int div_data_width = 32;

  // request function, one bit wide on the bus
  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  // request message, fn sits in the top bit
  typedef struct packed {
    div_fn_e                   fn;
    logic [div_data_width-1:0] a;
    logic [div_data_width-1:0] b;
  } div_req_msg_t;

  // response message, remainder in the upper half
  typedef struct packed {
    logic [div_data_width-1:0] rem;
    logic [div_data_width-1:0] quot;
  } div_resp_msg_t;

  // operand magnitudes handed from decode to execute
  typedef struct packed {
    logic [div_data_width-1:0] dividend_mag;
    logic [div_data_width-1:0] divisor_mag;
  } div_operands_t;

  // result sign flags, registered in decode and used by result
  typedef struct packed {
    logic quot_neg;
    logic rem_neg;
  } div_signs_t;

endpackage

`default_nettype wire

// ==== common/div_ctrl_pkg.sv ====
// control level types of the iterative divider
// execute FSM states and iteration constants
`default_nettype none

package div_ctrl_pkg;

  // one shift-subtract step per operand bit
  localparam int div_iterations = 32;

  // counter wide enough to hold div_iterations - 1
  localparam int div_count_width = 5;

  // execute FSM states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

// ==== divider/div_operand_decode.sv ====
// operand decode stage of the iterative divider
// magnitude conversion and result sign flag register
`timescale 1ns/1ns
`default_nettype none

module div_operand_decode (
  input  logic                       clk,
  input  logic                       reset,
  input  div_msg_pkg::div_req_msg_t  req_msg,
  input  logic                       sign_load,
  output div_msg_pkg::div_operands_t operands,
  output div_msg_pkg::div_signs_t    signs
);

  import div_msg_pkg::*;

  logic is_signed;
  logic a_neg;
  logic b_neg;

  // --------------------------------------------------
  // sign extraction
  // --------------------------------------------------

  assign is_signed = (req_msg.fn == div_fn_signed);

  // an operand only counts as negative for a signed request
  assign a_neg = is_signed && req_msg.a[div_data_width-1];
  assign b_neg = is_signed && req_msg.b[div_data_width-1];

  // --------------------------------------------------
  // magnitudes for the unsigned core
  // --------------------------------------------------

  always_comb begin
    // two's complement of negative operands
    // most negative value maps onto itself, which is the right magnitude
    operands.dividend_mag = a_neg ? -req_msg.a : req_msg.a;
    operands.divisor_mag  = b_neg ? -req_msg.b : req_msg.b;
  end

  // --------------------------------------------------
  // sign flags, loaded on the accepting edge
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      signs <= '0;
    end else if (sign_load) begin
      // quotient negative when exactly one operand is negative
      signs.quot_neg <= a_neg ^ b_neg;
      // remainder follows the dividend
      signs.rem_neg  <= a_neg;
    end
  end

endmodule

`default_nettype wire

// ==== divider/div_iter_execute.sv ====
// execute stage of the iterative divider
// control FSM, step counter and restoring shift-subtract datapath
`timescale 1ns/1ns
`default_nettype none

module div_iter_execute (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  input  div_msg_pkg::div_operands_t operands,
  input  logic                       result_free,
  output logic                       req_rdy,
  output logic                       sign_load,
  output logic                       done_val,
  output div_msg_pkg::div_resp_msg_t raw_result
);

  import div_msg_pkg::*;
  import div_ctrl_pkg::*;

  div_state_e                 state;
  logic [div_count_width-1:0] count;

  // working register, remainder in 64:32 and quotient in 31:0
  logic [2*div_data_width:0]  work;
  // divisor aligned to the remainder half
  logic [2*div_data_width:0]  divisor;

  logic [2*div_data_width:0]  shifted;
  logic [2*div_data_width:0]  diff;
  logic [2*div_data_width:0]  work_next;

  logic accept;
  logic last_step;

  // --------------------------------------------------
  // control outputs, straight from the state
  // --------------------------------------------------

  assign req_rdy   = (state == st_idle);
  assign done_val  = (state == st_done);
  assign accept    = req_rdy && req_val;
  // decode latches the sign flags on the same edge
  assign sign_load = accept;

  assign last_step = (count == '0);

  // --------------------------------------------------
  // one restoring step
  // --------------------------------------------------

  always_comb begin
    shifted = work << 1;
    diff    = shifted - divisor;
    // top bit set means the trial subtraction went negative
    if (diff[2*div_data_width]) begin
      // restore, new quotient bit is zero
      work_next = shifted;
    end else begin
      // keep the difference and shift in a one
      work_next = {diff[2*div_data_width:1], 1'b1};
    end
  end

  // --------------------------------------------------
  // FSM and counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_calc;
            count <= div_count_width'(div_iterations - 1);
          end
        end
        st_calc: begin
          // 32nd step leaves calc
          if (last_step) begin
            state <= st_done;
          end else begin
            count <= count - 1'b1;
          end
        end
        st_done: begin
          // wait here until result has room
          if (result_free) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // datapath registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      work    <= {{(div_data_width+1){1'b0}}, operands.dividend_mag};
      divisor <= {1'b0, operands.divisor_mag, {div_data_width{1'b0}}};
    end else if (state == st_calc) begin
      work <= work_next;
    end
  end

  // unsigned remainder and quotient
  assign raw_result = '{
    rem:  work[2*div_data_width-1:div_data_width],
    quot: work[div_data_width-1:0]
  };

endmodule

`default_nettype wire

// ==== divider/div_result_fixup.sv ====
// result stage of the iterative divider
// sign correction and the held response register
`timescale 1ns/1ns
`default_nettype none

module div_result_fixup (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       done_val,
  input  div_msg_pkg::div_resp_msg_t raw_result,
  input  div_msg_pkg::div_signs_t    signs,
  input  logic                       resp_rdy,
  output logic                       result_free,
  output div_msg_pkg::div_resp_msg_t resp_msg,
  output logic                       resp_val
);

  import div_msg_pkg::*;

  div_resp_msg_t fixed;
  logic          capture;

  // --------------------------------------------------
  // sign correction
  // --------------------------------------------------

  always_comb begin
    fixed.quot = signs.quot_neg ? -raw_result.quot : raw_result.quot;
    fixed.rem  = signs.rem_neg  ? -raw_result.rem  : raw_result.rem;
  end

  // --------------------------------------------------
  // response register
  // --------------------------------------------------

  // free when empty or drained on this edge
  assign result_free = !resp_val || resp_rdy;
  assign capture     = done_val && result_free;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (capture) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // payload only changes on a capture
  always_ff @(posedge clk) begin
    if (capture) begin
      resp_msg <= fixed;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/int_div_iterative.sv ====
// iterative 32-bit integer divider, top level
// joins decode, execute and result stages to the val/rdy ports
`timescale 1ns/1ns
`default_nettype none

module int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  div_msg_pkg::div_req_msg_t  req_msg,
  input  logic                       req_val,
  output logic                       req_rdy,
  output div_msg_pkg::div_resp_msg_t resp_msg,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  import div_msg_pkg::*;

  // decode to execute
  div_operands_t operands;
  // decode to result
  div_signs_t    signs;
  // execute to decode
  logic          sign_load;
  // execute to result hand-off
  logic          done_val;
  div_resp_msg_t raw_result;
  logic          result_free;

  div_operand_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .req_msg   (req_msg),
    .sign_load (sign_load),
    .operands  (operands),
    .signs     (signs)
  );

  div_iter_execute u_execute (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .operands    (operands),
    .result_free (result_free),
    .req_rdy     (req_rdy),
    .sign_load   (sign_load),
    .done_val    (done_val),
    .raw_result  (raw_result)
  );

  div_result_fixup u_result (
    .clk         (clk),
    .reset       (reset),
    .done_val    (done_val),
    .raw_result  (raw_result),
    .signs       (signs),
    .resp_rdy    (resp_rdy),
    .result_free (result_free),
    .resp_msg    (resp_msg),
    .resp_val    (resp_val)
  );

endmodule

`default_nettype wire

// ==== dv/int_div_asserts.sv ====
// handshake and FSM assertions for the divider stages
// bound into the execute and result stages
`timescale 1ns/1ns
`default_nettype none

module div_handshake_asserts (
  input logic                       clk,
  input logic                       reset,
  input div_ctrl_pkg::div_state_e   state,
  input logic                       req_val,
  input logic                       req_rdy,
  input logic                       sign_load,
  input logic                       resp_val,
  input logic                       resp_rdy,
  input div_msg_pkg::div_resp_msg_t resp_msg
);

  import div_ctrl_pkg::*;

  // idle holds until a request is taken, then ready goes away
  rdy_in_idle: assert property (@(posedge clk) disable iff (reset)
    req_rdy |=> ((state == st_idle) == !$past(req_val)))
    else $error("req_rdy does not follow st_idle");

  // held reply must not move until taken
  resp_held: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(resp_msg))
    else $error("resp_msg changed while stalled");

  // one load pulse per accepted request
  sign_on_accept: assert property (@(posedge clk) disable iff (reset)
    sign_load |=> !sign_load)
    else $error("sign_load without an accepted request");

endmodule

// execute side, response ports tied off
bind div_iter_execute div_handshake_asserts u_execute_asserts (
  .clk       (clk),
  .reset     (reset),
  .state     (state),
  .req_val   (req_val),
  .req_rdy   (req_rdy),
  .sign_load (sign_load),
  .resp_val  (1'b0),
  .resp_rdy  (1'b1),
  .resp_msg  ('0)
);

// result side, request ports tied off
bind div_result_fixup div_handshake_asserts u_result_asserts (
  .clk       (clk),
  .reset     (reset),
  .state     (div_ctrl_pkg::st_idle),
  .req_val   (1'b0),
  .req_rdy   (1'b1),
  .sign_load (1'b0),
  .resp_val  (resp_val),
  .resp_rdy  (resp_rdy),
  .resp_msg  (resp_msg)
);

`default_nettype wire

// ==== dv/int_div_tb.sv ====
// testbench for the iterative integer divider
// stimulus table, reference model, compare tasks, overlap test and timeout
`timescale 1ns/1ns
`default_nettype none

module int_div_tb;

  import div_msg_pkg::*;

  localparam int num_rows       = 26;
  localparam int timeout_cycles = num_rows * 80;
  // rising edges from the accepting edge through the one raising resp_val
  localparam int resp_latency   = 34;

  // one table row, request plus expected reply and back-pressure delay
  typedef struct packed {
    div_req_msg_t  req;
    div_resp_msg_t exp;
    logic [1:0]    delay;
  } row_t;

  logic          clk;
  logic          reset;
  div_req_msg_t  req_msg;
  logic          req_val;
  logic          req_rdy;
  div_resp_msg_t resp_msg;
  logic          resp_val;
  logic          resp_rdy;
  int            cycle_count;
  row_t          rows [num_rows];

  int_div_iterative UUT (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #50 clk = ~clk;

  // --------------------------------------------------
  // cycle counter and timeout
  // --------------------------------------------------

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout: the test did not finish within %0d cycles", timeout_cycles);
    end
  end

  // --------------------------------------------------
  // reference model and compare tasks
  // --------------------------------------------------

  function automatic div_resp_msg_t model_div(input div_req_msg_t r);
    div_resp_msg_t res;
    int            sa;
    int            sb;
    sa = r.a;
    sb = r.b;
    if (r.fn == div_fn_unsigned) begin
      // divide by zero gives all ones, remainder is the dividend
      res.quot = (r.b == 0) ? '1 : r.a / r.b;
      res.rem  = (r.b == 0) ? r.a : r.a % r.b;
    end else if (r.b == 0) begin
      res.quot = (sa < 0) ? 32'd1 : 32'hffff_ffff;
      res.rem  = r.a;
    end else if (r.a == 32'h8000_0000 && r.b == 32'hffff_ffff) begin
      // signed overflow wraps
      res.quot = 32'h8000_0000;
      res.rem  = '0;
    end else begin
      // truncation toward zero, remainder with the sign of a
      res.quot = sa / sb;
      res.rem  = sa % sb;
    end
    return res;
  endfunction

  function automatic row_t make_row(input div_fn_e fn, input logic [31:0] a,
                                    input logic [31:0] b, input logic [1:0] delay);
    row_t r;
    r.req   = '{fn: fn, a: a, b: b};
    r.exp   = model_div(r.req);
    r.delay = delay;
    return r;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("error at %0t ns: %s expected %0h got %0h", $time, sig, exp, act);
    $display("Simulation finished: FAIL");
    $fatal(1, "value mismatch on %s", sig);
  endtask

  task automatic check_resp(input div_resp_msg_t exp, input div_resp_msg_t act);
    if (act.rem !== exp.rem) report_mismatch("resp_msg.rem", exp.rem, act.rem);
    if (act.quot !== exp.quot) report_mismatch("resp_msg.quot", exp.quot, act.quot);
  endtask

  task automatic check_flag(input string sig, input logic act, input logic exp);
    if (act !== exp) report_mismatch(sig, 32'(exp), 32'(act));
  endtask

  task automatic check_count(input string sig, input int act, input int exp);
    if (act != exp) report_mismatch(sig, exp, act);
  endtask

  // --------------------------------------------------
  // request and response sequences
  // --------------------------------------------------

  // wait for req_rdy, the following rising edge is the accepting one
  // response ready is set up together with the request
  task automatic send_req(input div_req_msg_t m, input logic rdy);
    @(posedge clk);
    req_msg  <= m;
    req_val  <= 1'b1;
    resp_rdy <= rdy;
    do @(negedge clk); while (!req_rdy);
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  task automatic run_row(input row_t r);
    int c0;
    // ready up front only for rows without back-pressure
    send_req(r.req, r.delay == 0);
    @(negedge clk);
    c0 = cycle_count;
    do @(negedge clk); while (!resp_val);
    check_count("resp_val latency", cycle_count - c0 + 1, resp_latency);
    check_resp(r.exp, resp_msg);
    if (r.delay != 0) begin
      repeat (r.delay) @(posedge clk);
      resp_rdy <= 1'b1;
      // response still held after the stall
      @(negedge clk);
      check_flag("resp_val", resp_val, 1'b1);
      check_resp(r.exp, resp_msg);
    end
    // transfer edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    check_flag("resp_val", resp_val, 1'b0);
  endtask

  // second request computes while the first reply waits
  task automatic overlap_pair(input row_t ra, input row_t rb);
    send_req(ra.req, 1'b0);
    do @(negedge clk); while (!resp_val);
    check_resp(ra.exp, resp_msg);
    send_req(rb.req, 1'b0);
    repeat (resp_latency + 1) @(posedge clk);
    @(negedge clk);
    // rb finished and is stuck in st_done behind ra
    check_flag("req_rdy", req_rdy, 1'b0);
    check_flag("resp_val", resp_val, 1'b1);
    check_resp(ra.exp, resp_msg);
    @(posedge clk);
    resp_rdy <= 1'b1;
    // ra leaves and rb enters on the same edge
    @(posedge clk);
    @(negedge clk);
    check_flag("resp_val", resp_val, 1'b1);
    check_resp(rb.exp, resp_msg);
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    check_flag("resp_val", resp_val, 1'b0);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    req_msg     = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    cycle_count = 0;
    void'($urandom(32'h934a_7ed3));

    // directed unsigned rows, last one divides by zero
    rows[0]  = make_row(div_fn_unsigned, 32'd100, 32'd7, 2'd0);
    rows[1]  = make_row(div_fn_unsigned, 32'd7, 32'd100, 2'd1);
    rows[2]  = make_row(div_fn_unsigned, 32'hffff_ffff, 32'd1, 2'd0);
    rows[3]  = make_row(div_fn_unsigned, 32'hffff_ffff, 32'hffff_ffff, 2'd3);
    rows[4]  = make_row(div_fn_unsigned, 32'h8000_0000, 32'd3, 2'd0);
    rows[5]  = make_row(div_fn_unsigned, 32'h1234_5678, 32'd0, 2'd2);
    // signed rows, all four sign pairs then the corner cases
    rows[6]  = make_row(div_fn_signed, 32'd100, 32'd7, 2'd0);
    rows[7]  = make_row(div_fn_signed, -32'd100, 32'd7, 2'd1);
    rows[8]  = make_row(div_fn_signed, 32'd100, -32'd7, 2'd0);
    rows[9]  = make_row(div_fn_signed, -32'd100, -32'd7, 2'd2);
    rows[10] = make_row(div_fn_signed, 32'h8000_0000, 32'hffff_ffff, 2'd0);
    rows[11] = make_row(div_fn_signed, 32'd5, 32'd0, 2'd0);
    rows[12] = make_row(div_fn_signed, -32'd5, 32'd0, 2'd3);
    rows[13] = make_row(div_fn_signed, 32'h8000_0000, 32'd2, 2'd0);
    // random rows, divisor shifted down for a spread of sizes
    for (int i = 14; i < num_rows; i++) begin
      rows[i] = make_row(($urandom % 2 == 1) ? div_fn_signed : div_fn_unsigned,
                         $urandom, $urandom >> ($urandom % 32), 2'($urandom % 4));
    end

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("req_rdy", req_rdy, 1'b1);
    check_flag("resp_val", resp_val, 1'b0);

    for (int i = 0; i < num_rows; i++) begin
      run_row(rows[i]);
    end
    overlap_pair(rows[7], rows[num_rows-1]);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/div_msg_pkg.sv
common/div_ctrl_pkg.sv
divider/div_operand_decode.sv
divider/div_iter_execute.sv
divider/div_result_fixup.sv
rtl/int_div_iterative.sv
dv/int_div_asserts.sv
dv/int_div_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := int_div_tb
FILELIST := sources.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)
